/* include/wbuf_macros.svh */
// write buffer sizing macros shared by the package, the RTL and the testbench

`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

////////////////////////////////////////////////////////////
// buffer geometry
////////////////////////////////////////////////////////////

// number of word entries held in the buffer
`define WBUF_DEPTH 8

// number of transfer IDs that can be outstanding at once
`define WBUF_MAX_TX 4

////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////

// physical address width
`define WBUF_PLEN 32

// bytes per buffered word, one byte enable each
`define WBUF_WORD_BYTES 8

`endif

/* src/wbuf_pkg.sv */
// write buffer types plus the size, byte enable and replication helpers
`default_nettype none

`include "wbuf_macros.svh"

package wbuf_pkg;

  // byte offset width inside a word
  localparam int OffW = $clog2(`WBUF_WORD_BYTES);

  typedef logic [`WBUF_PLEN-1:0]              paddr_t;
  typedef logic [`WBUF_PLEN-OffW-1:0]         wtag_t;
  typedef logic [`WBUF_WORD_BYTES*8-1:0]      data_t;
  typedef logic [`WBUF_WORD_BYTES-1:0]        be_t;
  typedef logic [OffW-1:0]                    off_t;
  typedef logic [$clog2(`WBUF_DEPTH)-1:0]     ptr_t;
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0]    txid_t;

  // one buffered word with per-byte valid/dirty/txblock state
  typedef struct packed {
    wtag_t wtag;
    data_t data;
    be_t   valid;
    be_t   dirty;
    be_t   txblock;
  } entry_t;

  // one in-flight transfer
  typedef struct packed {
    logic vld;
    ptr_t ptr;
    be_t  be;
  } tx_stat_t;

  // transfer size code
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_t;

  // offset of the lowest set byte, 0 for an empty mask
  function automatic off_t low_off(input be_t be);
    off_t off;
    off = '0;
    for (int k = `WBUF_WORD_BYTES - 1; k >= 0; k--) begin
      if (be[k]) begin
        off = off_t'(k);
      end
    end
    return off;
  endfunction

  // byte enables covered by a transfer of this size at this offset
  function automatic be_t to_be(input off_t off, input size_t size);
    logic [15:0] mask;
    mask = (16'd1 << (5'd1 << size)) - 16'd1;
    mask = mask << off;
    return mask[`WBUF_WORD_BYTES-1:0];
  endfunction

  // largest aligned size starting at the lowest set byte
  // every byte of the chunk has to be set in the mask
  function automatic size_t to_size(input be_t be);
    off_t  off;
    be_t   mask;
    size_t size;
    off  = low_off(be);
    size = SIZE_B;
    // an aligned chunk that fits implies all smaller ones fit too
    for (int s = 1; s < 4; s++) begin
      mask = to_be(off, size_t'(s));
      if ((int'(off) % (1 << s)) == 0 && (be & mask) == mask) begin
        size = size_t'(s);
      end
    end
    return size;
  endfunction

  // copy the chunk at the offset into every lane of the bus
  function automatic data_t rep_data(input data_t data, input off_t off, input size_t size);
    data_t rep;
    case (size)
      SIZE_B:  rep = {8{data[off*8 +: 8]}};
      SIZE_H:  rep = {4{data[off*8 +: 16]}};
      SIZE_W:  rep = {2{data[off*8 +: 32]}};
      default: rep = data;
    endcase
    return rep;
  endfunction

endpackage

`default_nettype wire

/* src/wbuf_rr_arb.sv */
// round-robin arbiter with optional lock-in, returns the granted index
`timescale 1ns/1ps
`default_nettype none

module wbuf_rr_arb #(
  parameter int NumIn = 4
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // one request bit per input
  input  wire logic [NumIn-1:0]      req_i,
  // the selected index is consumed this cycle
  input  wire logic                  gnt_i,
  // hold a pending selection until it is granted
  input  wire logic                  lock_i,
  output logic [((NumIn > 1) ? $clog2(NumIn) : 1)-1:0] idx_o
);

  localparam int IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  // round-robin start point
  logic [IdxW-1:0] rr_q;
  // locked selection from an earlier cycle
  logic            lock_q;
  logic [IdxW-1:0] lock_idx_q;
  // fresh pick from the search
  logic [IdxW-1:0] sel_idx;
  logic            hold;

  ////////////////////////////////////////////////////////////
  // search
  ////////////////////////////////////////////////////////////

  // first request at or after the pointer, wrapping around
  always_comb begin : p_search
    int unsigned cand;
    sel_idx = rr_q;
    for (int k = NumIn - 1; k >= 0; k--) begin
      cand = (int'(rr_q) + k) % NumIn;
      if (req_i[cand]) begin
        sel_idx = IdxW'(cand);
      end
    end
  end

  // a locked index stays put while it still requests
  assign idx_o = (lock_q && req_i[lock_idx_q]) ? lock_idx_q : sel_idx;

  // pending and not taken this cycle
  assign hold = lock_i && (|req_i) && !gnt_i;

  ////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= hold;
      if (hold) begin
        lock_idx_q <= idx_o;
      end
      // move past the winner so others get a turn
      if (gnt_i) begin
        rr_q <= (idx_o == IdxW'(NumIn - 1)) ? '0 : idx_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/wbuf_store.sv */
// coalescing entry storage with per-byte valid, dirty and txblock state
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_store import wbuf_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // core write port
  input  wire logic                      data_req_i,
  input  wire paddr_t                    addr_i,
  input  wire data_t                     wdata_i,
  input  wire be_t                       be_i,
  output logic                           data_gnt_o,
  // transfer issued to memory
  input  wire logic                      issue_i,
  input  wire ptr_t                      issue_ptr_i,
  input  wire be_t                       issue_be_i,
  // transfer retired by a response
  input  wire logic                      evict_i,
  input  wire ptr_t                      evict_ptr_i,
  input  wire be_t                       evict_be_i,
  // registered state towards the issue stage
  output entry_t [`WBUF_DEPTH-1:0]       entries_o,
  output logic   [`WBUF_DEPTH-1:0]       dirty_o,
  output logic                           empty_o
);

  // byte state, cleared on reset
  be_t   [`WBUF_DEPTH-1:0] valid_q, valid_d;
  be_t   [`WBUF_DEPTH-1:0] dirty_q, dirty_d;
  be_t   [`WBUF_DEPTH-1:0] txblk_q, txblk_d;
  // word payload
  wtag_t [`WBUF_DEPTH-1:0] wtag_q;
  data_t [`WBUF_DEPTH-1:0] data_q;

  logic  [`WBUF_DEPTH-1:0] valid;
  logic  [`WBUF_DEPTH-1:0] hit;
  ptr_t                    hit_ptr;
  ptr_t                    free_ptr;
  ptr_t                    wr_ptr;
  wtag_t                   req_wtag;
  logic                    full;
  logic                    wr_en;

  ////////////////////////////////////////////////////////////
  // per entry flags
  ////////////////////////////////////////////////////////////

  assign req_wtag = addr_i[`WBUF_PLEN-1:OffW];

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_flags
    assign valid[k] = |valid_q[k];
    assign hit[k]   = valid[k] && (wtag_q[k] == req_wtag);
    // a word with bytes in flight waits for its response,
    // two transfers to one word could pass each other in memory
    assign dirty_o[k] = !(|txblk_q[k]) && |(valid_q[k] & dirty_q[k]);
    assign entries_o[k] = entry_t'{
      wtag:    wtag_q[k],
      data:    data_q[k],
      valid:   valid_q[k],
      dirty:   dirty_q[k],
      txblock: txblk_q[k]
    };
  end

  // lowest matching and lowest free entry
  always_comb begin : p_ptr
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = ptr_t'(k);
      end
      if (!valid[k]) begin
        free_ptr = ptr_t'(k);
      end
    end
  end

  assign full       = &valid;
  assign wr_ptr     = (|hit) ? hit_ptr : free_ptr;
  // merge into a hit, otherwise need a free slot
  assign data_gnt_o = data_req_i && ((|hit) || !full);
  assign wr_en      = data_gnt_o;
  assign empty_o    = !(|valid);

  ////////////////////////////////////////////////////////////
  // byte state update
  ////////////////////////////////////////////////////////////

  always_comb begin : p_state
    valid_d = valid_q;
    dirty_d = dirty_q;
    txblk_d = txblk_q;

    // response back, unblock the bytes
    // clean ones leave, rewritten ones stay for another transfer
    if (evict_i) begin
      for (int k = 0; k < `WBUF_WORD_BYTES; k++) begin
        if (evict_be_i[k]) begin
          txblk_d[evict_ptr_i][k] = 1'b0;
          if (!dirty_q[evict_ptr_i][k]) begin
            valid_d[evict_ptr_i][k] = 1'b0;
          end
        end
      end
    end

    // bytes handed to memory
    if (issue_i) begin
      for (int k = 0; k < `WBUF_WORD_BYTES; k++) begin
        if (issue_be_i[k]) begin
          dirty_d[issue_ptr_i][k] = 1'b0;
          txblk_d[issue_ptr_i][k] = 1'b1;
        end
      end
    end

    // new write last, so a byte in flight goes back to dirty
    if (wr_en) begin
      for (int k = 0; k < `WBUF_WORD_BYTES; k++) begin
        if (be_i[k]) begin
          valid_d[wr_ptr][k] = 1'b1;
          dirty_d[wr_ptr][k] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_regs
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      txblk_q <= '0;
    end else begin
      valid_q <= valid_d;
      dirty_q <= dirty_d;
      txblk_q <= txblk_d;
    end
  end

  // payload, only enabled bytes are replaced
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en) begin
      wtag_q[wr_ptr] <= req_wtag;
      for (int k = 0; k < `WBUF_WORD_BYTES; k++) begin
        if (be_i[k]) begin
          data_q[wr_ptr][k*8 +: 8] <= wdata_i[k*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/wbuf_issue.sv */
// dirty entry selection and aligned transfer generation for the memory port
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_issue import wbuf_pkg::*; (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  // registered buffer state
  input  wire entry_t [`WBUF_DEPTH-1:0]  entries_i,
  input  wire logic   [`WBUF_DEPTH-1:0]  dirty_i,
  // slot availability from the tracker
  input  wire logic                      free_slot_i,
  input  wire txid_t                     free_id_i,
  // memory request channel
  input  wire logic                      miss_ack_i,
  output logic                           miss_req_o,
  output paddr_t                         miss_paddr_o,
  output size_t                          miss_size_o,
  output data_t                          miss_wdata_o,
  output txid_t                          miss_id_o,
  // handshake event towards store and tracker
  output logic                           issue_o,
  output ptr_t                           issue_ptr_o,
  output be_t                            issue_be_o
);

  ptr_t   dirty_ptr;
  entry_t sel;
  be_t    bdirty;
  off_t   off;
  size_t  size;

  // stay on one entry while the memory side stalls
  wbuf_rr_arb #(
    .NumIn ( `WBUF_DEPTH )
  ) i_dirty_arb (
    .clk_i  ( clk_i     ),
    .rst_ni ( rst_ni    ),
    .req_i  ( dirty_i   ),
    .gnt_i  ( issue_o   ),
    .lock_i ( 1'b1      ),
    .idx_o  ( dirty_ptr )
  );

  ////////////////////////////////////////////////////////////
  // split into aligned chunks
  ////////////////////////////////////////////////////////////

  assign sel    = entries_i[dirty_ptr];
  assign bdirty = sel.valid & sel.dirty;

  // lowest dirty byte starts the chunk
  // a gapped mask like 0011_1001 goes out over several transfers
  assign off  = low_off(bdirty);
  assign size = to_size(bdirty);

  ////////////////////////////////////////////////////////////
  // request outputs
  ////////////////////////////////////////////////////////////

  assign miss_req_o   = (|dirty_i) && free_slot_i;
  assign miss_paddr_o = {sel.wtag, off};
  assign miss_size_o  = size;
  // narrow transfers see their chunk in every lane
  assign miss_wdata_o = rep_data(sel.data, off, size);
  assign miss_id_o    = free_id_i;

  assign issue_o     = miss_req_o && miss_ack_i;
  assign issue_ptr_o = dirty_ptr;
  assign issue_be_o  = to_be(off, size);

endmodule

`default_nettype wire

/* src/wbuf_tx_track.sv */
// transfer slot table, free ID pick and returned ID FIFO feeding retirement
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_tx_track import wbuf_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // allocation at the issue edge
  input  wire logic     issue_i,
  input  wire ptr_t     issue_ptr_i,
  input  wire be_t      issue_be_i,
  // write responses, never stalled
  input  wire logic     miss_rtrn_vld_i,
  input  wire txid_t    miss_rtrn_id_i,
  // slot availability
  output logic          free_slot_o,
  output txid_t         free_id_o,
  // retirement towards the store
  output logic          evict_o,
  output ptr_t          evict_ptr_o,
  output be_t           evict_be_o
);

  localparam int CntW = $clog2(`WBUF_MAX_TX + 1);

  tx_stat_t [`WBUF_MAX_TX-1:0] tx_q, tx_d;
  logic     [`WBUF_MAX_TX-1:0] tx_vld;

  // returned IDs, at most one per outstanding slot
  txid_t           fifo_q [`WBUF_MAX_TX];
  txid_t           rd_ptr_q;
  txid_t           wr_ptr_q;
  logic [CntW-1:0] cnt_q;
  txid_t           rtrn_id;

  function automatic txid_t inc_id(input txid_t id);
    return (id == txid_t'(`WBUF_MAX_TX - 1)) ? '0 : id + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // free ID selection
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < `WBUF_MAX_TX; k++) begin : gen_vld
    assign tx_vld[k] = tx_q[k].vld;
  end

  assign free_slot_o = |(~tx_vld);

  wbuf_rr_arb #(
    .NumIn ( `WBUF_MAX_TX )
  ) i_id_arb (
    .clk_i  ( clk_i     ),
    .rst_ni ( rst_ni    ),
    .req_i  ( ~tx_vld   ),
    .gnt_i  ( issue_i   ),
    .lock_i ( 1'b0      ),
    .idx_o  ( free_id_o )
  );

  ////////////////////////////////////////////////////////////
  // returned ID FIFO
  ////////////////////////////////////////////////////////////

  // head only shows up after the push edge
  assign rtrn_id     = fifo_q[rd_ptr_q];
  assign evict_o     = (cnt_q != '0);
  assign evict_ptr_o = tx_q[rtrn_id].ptr;
  assign evict_be_o  = tx_q[rtrn_id].be;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fifo_ctrl
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (miss_rtrn_vld_i) begin
        wr_ptr_q <= inc_id(wr_ptr_q);
      end
      // retirement never stalls, pop one per cycle
      if (evict_o) begin
        rd_ptr_q <= inc_id(rd_ptr_q);
      end
      cnt_q <= cnt_q + CntW'(miss_rtrn_vld_i) - CntW'(evict_o);
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_mem
    if (miss_rtrn_vld_i) begin
      fifo_q[wr_ptr_q] <= miss_rtrn_id_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // slot table
  ////////////////////////////////////////////////////////////

  always_comb begin : p_slots
    tx_d = tx_q;
    if (evict_o) begin
      tx_d[rtrn_id].vld = 1'b0;
    end
    // free ID is never the slot being retired, that one is still valid
    if (issue_i) begin
      tx_d[free_id_o].vld = 1'b1;
      tx_d[free_id_o].ptr = issue_ptr_i;
      tx_d[free_id_o].be  = issue_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_slot_regs
    if (!rst_ni) begin
      tx_q <= '0;
    end else begin
      tx_q <= tx_d;
    end
  end

endmodule

`default_nettype wire

/* src/wbuf_top.sv */
// write buffer top level joining storage, issue and transfer tracking
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_top import wbuf_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  // core store port
  input  wire logic    data_req_i,
  input  wire paddr_t  addr_i,
  input  wire data_t   wdata_i,
  input  wire be_t     be_i,
  output logic         data_gnt_o,
  // memory write request
  output logic         miss_req_o,
  input  wire logic    miss_ack_i,
  output paddr_t       miss_paddr_o,
  output size_t        miss_size_o,
  output data_t        miss_wdata_o,
  output txid_t        miss_id_o,
  // memory write response
  input  wire logic    miss_rtrn_vld_i,
  input  wire txid_t   miss_rtrn_id_i,
  // nothing held
  output logic         empty_o
);

  entry_t [`WBUF_DEPTH-1:0] entries;
  logic   [`WBUF_DEPTH-1:0] dirty;
  // issue event
  logic                     issue;
  ptr_t                     issue_ptr;
  be_t                      issue_be;
  // slot state
  logic                     free_slot;
  txid_t                    free_id;
  // retirement
  logic                     evict;
  ptr_t                     evict_ptr;
  be_t                      evict_be;

  wbuf_store i_store (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .data_req_i  ( data_req_i ),
    .addr_i      ( addr_i     ),
    .wdata_i     ( wdata_i    ),
    .be_i        ( be_i       ),
    .data_gnt_o  ( data_gnt_o ),
    .issue_i     ( issue      ),
    .issue_ptr_i ( issue_ptr  ),
    .issue_be_i  ( issue_be   ),
    .evict_i     ( evict      ),
    .evict_ptr_i ( evict_ptr  ),
    .evict_be_i  ( evict_be   ),
    .entries_o   ( entries    ),
    .dirty_o     ( dirty      ),
    .empty_o     ( empty_o    )
  );

  wbuf_issue i_issue (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .entries_i    ( entries      ),
    .dirty_i      ( dirty        ),
    .free_slot_i  ( free_slot    ),
    .free_id_i    ( free_id      ),
    .miss_ack_i   ( miss_ack_i   ),
    .miss_req_o   ( miss_req_o   ),
    .miss_paddr_o ( miss_paddr_o ),
    .miss_size_o  ( miss_size_o  ),
    .miss_wdata_o ( miss_wdata_o ),
    .miss_id_o    ( miss_id_o    ),
    .issue_o      ( issue        ),
    .issue_ptr_o  ( issue_ptr    ),
    .issue_be_o   ( issue_be     )
  );

  wbuf_tx_track i_tx_track (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .issue_i         ( issue           ),
    .issue_ptr_i     ( issue_ptr       ),
    .issue_be_i      ( issue_be        ),
    .miss_rtrn_vld_i ( miss_rtrn_vld_i ),
    .miss_rtrn_id_i  ( miss_rtrn_id_i  ),
    .free_slot_o     ( free_slot       ),
    .free_id_o       ( free_id         ),
    .evict_o         ( evict           ),
    .evict_ptr_o     ( evict_ptr       ),
    .evict_be_o      ( evict_be        )
  );

endmodule

`default_nettype wire

/* bench/wbuf_tb.sv */
// directed testbench for the coalescing write buffer with a memory responder model
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_tb import wbuf_pkg::*; ();

  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 2000;
  // upper bound for any single wait inside a test
  localparam int WaitLimit     = 200;

  logic        clk;
  logic        rst_n;
  // core port
  logic        data_req;
  paddr_t      addr;
  data_t       wdata;
  be_t         be;
  logic        data_gnt;
  // memory request channel
  logic        miss_req;
  logic        miss_ack;
  paddr_t      miss_paddr;
  logic [1:0]  miss_size;
  data_t       miss_wdata;
  txid_t       miss_id;
  // memory response channel
  logic        rtrn_vld;
  txid_t       rtrn_id;
  logic        empty;

  // transfers seen by the responder in issue order
  paddr_t      rec_addr[$];
  logic [1:0]  rec_size[$];
  data_t       rec_data[$];
  txid_t       rec_id[$];
  // how many recorded transfers got a response
  int          resp_idx;
  int          n_err;
  int          n_tmo;
  logic [31:0] rng;

  wbuf_top i_dut (
    .clk_i           ( clk        ),
    .rst_ni          ( rst_n      ),
    .data_req_i      ( data_req   ),
    .addr_i          ( addr       ),
    .wdata_i         ( wdata      ),
    .be_i            ( be         ),
    .data_gnt_o      ( data_gnt   ),
    .miss_req_o      ( miss_req   ),
    .miss_ack_i      ( miss_ack   ),
    .miss_paddr_o    ( miss_paddr ),
    .miss_size_o     ( miss_size  ),
    .miss_wdata_o    ( miss_wdata ),
    .miss_id_o       ( miss_id    ),
    .miss_rtrn_vld_i ( rtrn_vld   ),
    .miss_rtrn_id_i  ( rtrn_id    ),
    .empty_o         ( empty      )
  );

  ////////////////////////////////////////////////////////////
  // clock, responder, watchdog
  ////////////////////////////////////////////////////////////

  initial begin : p_clk
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // the handshake completes on this edge with the pre-edge values
  always @(posedge clk) begin : p_mem_rec
    if (rst_n && miss_req && miss_ack) begin
      rec_addr.push_back(miss_paddr);
      rec_size.push_back(miss_size);
      rec_data.push_back(miss_wdata);
      rec_id.push_back(miss_id);
    end
  end

  initial begin : p_watchdog
    repeat (NumTests * CyclesPerTest) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish",
             NumTests * CyclesPerTest);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // lane i carries chunk byte (i mod chunk size)
  function automatic data_t lane_fill(input data_t d, input int off, input int nbytes);
    data_t r;
    for (int i = 0; i < 8; i++) begin
      r[i*8 +: 8] = d[(off + (i % nbytes))*8 +: 8];
    end
    return r;
  endfunction

  task automatic report_err(input string msg);
    n_err++;
    $display("ERR @%0t ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    n_tmo++;
    $display("timed out at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic start_test(input string name, input logic ack);
    @(negedge clk);
    $display("%0t ns: %s", $time, name);
    rec_addr.delete();
    rec_size.delete();
    rec_data.delete();
    rec_id.delete();
    resp_idx = 0;
    @(posedge clk);
    miss_ack <= ack;
  endtask

  // hold a write until the buffer grants it
  task automatic write_word(input paddr_t a, input data_t d, input be_t b);
    int cnt;
    cnt = 0;
    @(posedge clk);
    data_req <= 1'b1;
    addr     <= a;
    wdata    <= d;
    be       <= b;
    @(negedge clk);
    while (!data_gnt && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (!data_gnt) begin
      report_timeout("a write grant");
    end
    @(posedge clk);
    data_req <= 1'b0;
  endtask

  // one cycle of response valid
  task automatic send_resp(input txid_t id);
    @(posedge clk);
    rtrn_vld <= 1'b1;
    rtrn_id  <= id;
    @(posedge clk);
    rtrn_vld <= 1'b0;
  endtask

  task automatic wait_xfers(input int n, input string what);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (rec_id.size() < n && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (rec_id.size() < n) begin
      report_timeout(what);
    end
  endtask

  task automatic wait_empty(input string what);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!empty && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (!empty) begin
      report_timeout(what);
    end
  endtask

  // ack everything and answer in issue order until nothing is held
  task automatic drain();
    int cnt;
    cnt = 0;
    @(posedge clk);
    miss_ack <= 1'b1;
    @(negedge clk);
    while (!(empty && resp_idx == rec_id.size()) && cnt < WaitLimit) begin
      if (resp_idx < rec_id.size()) begin
        send_resp(rec_id[resp_idx]);
        resp_idx++;
      end
      @(negedge clk);
      cnt++;
    end
    if (!empty) begin
      report_timeout("the buffer to drain");
    end
  endtask

  task automatic check_xfer(input int idx, input paddr_t ea, input int es, input data_t ed);
    if (idx >= rec_id.size()) begin
      report_err($sformatf("transfer %0d missing", idx));
    end else begin
      if (rec_addr[idx] !== ea) begin
        report_err($sformatf("transfer %0d addr %h, expected %h", idx, rec_addr[idx], ea));
      end
      if (int'(rec_size[idx]) != es) begin
        report_err($sformatf("transfer %0d size %0d, expected %0d", idx, rec_size[idx], es));
      end
      if (rec_data[idx] !== ed) begin
        report_err($sformatf("transfer %0d data %h, expected %h", idx, rec_data[idx], ed));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_single_dword();
    paddr_t a;
    data_t  d;
    start_test("single dword write", 1'b1);
    a = rand32() & 32'hFFFF_FFF8;
    d = {rand32(), rand32()};
    write_word(a, d, 8'hFF);
    wait_xfers(1, "the dword transfer");
    check_xfer(0, a, 3, d);
    if (empty) begin
      report_err("empty while the dword is in flight");
    end
    send_resp(rec_id[0]);
    resp_idx = 1;
    wait_empty("empty after the dword response");
    if (rec_id.size() != 1) begin
      report_err($sformatf("%0d transfers for one dword, expected 1", rec_id.size()));
    end
  endtask

  task automatic test_coalesce();
    paddr_t a;
    data_t  d0;
    data_t  d1;
    start_test("coalescing two writes", 1'b0);
    a  = rand32() & 32'hFFFF_FFF8;
    d0 = {rand32(), rand32()};
    d1 = {rand32(), rand32()};
    write_word(a, d0, 8'h0F);
    write_word(a, d1, 8'hF0);
    @(negedge clk);
    // held request already shows the merged word
    if (!miss_req || miss_size != 2'd3) begin
      report_err("request not held with the merged payload while ack is low");
    end
    @(posedge clk);
    miss_ack <= 1'b1;
    wait_xfers(1, "the merged transfer");
    check_xfer(0, a, 3, {d1[63:32], d0[31:0]});
    send_resp(rec_id[0]);
    resp_idx = 1;
    wait_empty("empty after the merged response");
    if (rec_id.size() != 1) begin
      report_err($sformatf("%0d transfers after merge, expected 1", rec_id.size()));
    end
  endtask

  task automatic test_split();
    paddr_t a;
    data_t  d;
    int     offs[3];
    int     sizes[3];
    start_test("splitting a gapped byte mask", 1'b1);
    offs  = '{0, 3, 4};
    sizes = '{0, 0, 1};
    a = rand32() & 32'hFFFF_FFF8;
    d = {rand32(), rand32()};
    write_word(a, d, 8'b0011_1001);
    // the next chunk of a word goes out once the previous one returned
    for (int i = 0; i < 3; i++) begin
      wait_xfers(i + 1, "a split transfer");
      check_xfer(i, a + paddr_t'(offs[i]), sizes[i], lane_fill(d, offs[i], 1 << sizes[i]));
      if (rec_id.size() > i) begin
        send_resp(rec_id[i]);
      end
    end
    resp_idx = 3;
    wait_empty("empty after the split transfers");
    if (rec_id.size() != 3) begin
      report_err($sformatf("%0d split transfers, expected 3", rec_id.size()));
    end
  endtask

  task automatic test_rewrite();
    paddr_t a;
    data_t  d0;
    data_t  d1;
    start_test("rewrite while in flight", 1'b1);
    a  = rand32() & 32'hFFFF_FFF8;
    d0 = {rand32(), rand32()};
    d1 = {rand32(), rand32()};
    write_word(a, d0, 8'h01);
    wait_xfers(1, "the first byte transfer");
    check_xfer(0, a, 0, lane_fill(d0, 0, 1));
    write_word(a, d1, 8'h01);
    // ack is high, so an early resend would be recorded within these cycles
    repeat (4) @(negedge clk);
    if (rec_id.size() != 1) begin
      report_err("byte sent again before its response returned");
    end
    send_resp(rec_id[0]);
    wait_xfers(2, "the resent byte");
    check_xfer(1, a, 0, lane_fill(d1, 0, 1));
    if (empty) begin
      report_err("empty before the second response");
    end
    if (rec_id.size() > 1) begin
      send_resp(rec_id[1]);
    end
    resp_idx = 2;
    wait_empty("empty after the second response");
  endtask

  task automatic test_full();
    paddr_t base;
    paddr_t a_new;
    start_test("full buffer", 1'b0);
    base  = rand32() & 32'hFFFF_FF00;
    a_new = base + paddr_t'(`WBUF_DEPTH * 8);
    for (int k = 0; k < `WBUF_DEPTH; k++) begin
      write_word(base + paddr_t'(k * 8), {rand32(), rand32()}, 8'hFF);
    end
    // a new word finds no free entry
    @(posedge clk);
    data_req <= 1'b1;
    addr     <= a_new;
    wdata    <= {rand32(), rand32()};
    be       <= 8'hFF;
    repeat (3) begin
      @(negedge clk);
      if (data_gnt) begin
        report_err("new word granted with every entry occupied");
      end
    end
    @(posedge clk);
    data_req <= 1'b0;
    // merge into a stored word still works
    write_word(base + 32'd8, {rand32(), rand32()}, 8'h0F);
    // exactly one handshake
    @(posedge clk);
    miss_ack <= 1'b1;
    @(posedge clk);
    miss_ack <= 1'b0;
    @(negedge clk);
    if (rec_id.size() != 1) begin
      report_err($sformatf("%0d transfers acknowledged, expected 1", rec_id.size()));
    end
    if (rec_id.size() > 0) begin
      send_resp(rec_id[0]);
      resp_idx = 1;
    end
    write_word(a_new, {rand32(), rand32()}, 8'hFF);
    drain();
  endtask

  task automatic test_slots();
    paddr_t base;
    start_test("transfer slot limit", 1'b1);
    base = rand32() & 32'hFFFF_FF00;
    for (int k = 0; k <= `WBUF_MAX_TX; k++) begin
      write_word(base + paddr_t'(k * 8), {rand32(), rand32()}, 8'hFF);
    end
    wait_xfers(`WBUF_MAX_TX, "transfers up to the slot limit");
    repeat (5) begin
      @(negedge clk);
      if (miss_req) begin
        report_err("request raised with every slot in use");
      end
    end
    if (rec_id.size() != `WBUF_MAX_TX) begin
      report_err($sformatf("%0d outstanding transfers, expected %0d",
                           rec_id.size(), `WBUF_MAX_TX));
    end else begin
      for (int i = 0; i < `WBUF_MAX_TX; i++) begin
        for (int j = i + 1; j < `WBUF_MAX_TX; j++) begin
          if (rec_id[i] == rec_id[j]) begin
            report_err($sformatf("transfers %0d and %0d share ID %0d", i, j, rec_id[i]));
          end
        end
      end
      // newest first
      for (int k = `WBUF_MAX_TX - 1; k >= 0; k--) begin
        send_resp(rec_id[k]);
      end
      resp_idx = `WBUF_MAX_TX;
    end
    drain();
    if (rec_id.size() != `WBUF_MAX_TX + 1) begin
      report_err($sformatf("%0d transfers in total, expected %0d",
                           rec_id.size(), `WBUF_MAX_TX + 1));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : p_main
    rng      = 32'd24;
    n_err    = 0;
    n_tmo    = 0;
    resp_idx = 0;
    rst_n    = 1'b0;
    data_req = 1'b0;
    addr     = '0;
    wdata    = '0;
    be       = '0;
    miss_ack = 1'b0;
    rtrn_vld = 1'b0;
    rtrn_id  = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (data_gnt || miss_req || !empty) begin
      report_err("outputs not idle after reset");
    end
    test_single_dword();
    test_coalesce();
    test_split();
    test_rewrite();
    test_full();
    test_slots();
    $display("run complete: %0d value errors, %0d timeouts", n_err, n_tmo);
    if (n_err == 0 && n_tmo == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* wbuf.f */
+incdir+include
src/wbuf_pkg.sv
src/wbuf_rr_arb.sv
src/wbuf_store.sv
src/wbuf_issue.sv
src/wbuf_tx_track.sv
src/wbuf_top.sv
bench/wbuf_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the write buffer testbench with Verilator

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f wbuf.f --top-module wbuf_tb \
  -Mdir "$OBJ" -o wbuf_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/wbuf_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
exit 0
